// File: ipod_types_pkg.sv
`default_nettype none

package ipod_types_pkg;

  // ====================================================================
  // Datapath widths
  // ====================================================================

  // One audio sample
  typedef logic [15:0] sample_t;

  // One flash data word, two samples side by side
  typedef logic [31:0] word_t;

  // Flash word address
  typedef logic [22:0] addr_t;

  // Sample-rate divider, counted in CLK_50M cycles
  typedef logic [15:0] div_t;

  // ====================================================================
  // Default timing
  // ====================================================================

  // About 44 kHz from 50 MHz
  localparam div_t DEFAULT_DIV_C = 16'd1135;

  localparam div_t SPEED_STEP_C = 16'd8;
  localparam div_t MIN_DIV_C = 16'd400;
  localparam div_t MAX_DIV_C = 16'd4000;

  // Key repeat every 100 ms
  localparam int unsigned REPEAT_CYCLES_C = 5_000_000;

  localparam addr_t LAST_ADDR_C = 23'h7FFFF;

endpackage

`default_nettype wire

// File: ipod_cmd_pkg.sv
`default_nettype none

package ipod_cmd_pkg;

  typedef logic [7:0] ascii_t;

  // Keyboard commands, upper and lower case
  localparam ascii_t CMD_PLAY_C = 8'h45;
  localparam ascii_t CMD_PLAY_LC_C = 8'h65;
  localparam ascii_t CMD_PAUSE_C = 8'h44;
  localparam ascii_t CMD_PAUSE_LC_C = 8'h64;
  localparam ascii_t CMD_FWD_C = 8'h46;
  localparam ascii_t CMD_FWD_LC_C = 8'h66;
  localparam ascii_t CMD_BACK_C = 8'h42;
  localparam ascii_t CMD_BACK_LC_C = 8'h62;
  localparam ascii_t CMD_RESTART_C = 8'h52;
  localparam ascii_t CMD_RESTART_LC_C = 8'h72;

  // Playback direction
  typedef enum logic {
    DIR_FORWARD,
    DIR_BACKWARD
  } dir_e;

  // Flash reader states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQUEST,
    ST_WAIT_DATA,
    ST_SECOND_HALF
  } reader_state_e;

endpackage

`default_nettype wire

// File: speed_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module speed_ctrl #(
  parameter ipod_types_pkg::div_t DEFAULT_DIV = ipod_types_pkg::DEFAULT_DIV_C,
  parameter ipod_types_pkg::div_t SPEED_STEP = ipod_types_pkg::SPEED_STEP_C,
  parameter ipod_types_pkg::div_t MIN_DIV = ipod_types_pkg::MIN_DIV_C,
  parameter ipod_types_pkg::div_t MAX_DIV = ipod_types_pkg::MAX_DIV_C,
  parameter int unsigned REPEAT_CYCLES = ipod_types_pkg::REPEAT_CYCLES_C
) (
  input  wire                        CLK_50M,
  input  wire                        arst_n,
  input  wire                        speed_up_n,
  input  wire                        speed_down_n,
  input  wire                        speed_reset_n,
  output ipod_types_pkg::div_t       rate_count
);

  localparam int RPT_W = (REPEAT_CYCLES > 1) ? $clog2(REPEAT_CYCLES) : 1;

  // Two-flop synchronisers, keys idle high
  logic [1:0] up_sync;
  logic [1:0] down_sync;
  logic [1:0] reset_sync;

  logic [RPT_W-1:0] rpt_count;
  logic             rpt_strobe;

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      up_sync <= 2'b11;
      down_sync <= 2'b11;
      reset_sync <= 2'b11;
    end
    else
    begin
      up_sync <= {up_sync[0], speed_up_n};
      down_sync <= {down_sync[0], speed_down_n};
      reset_sync <= {reset_sync[0], speed_reset_n};
    end
  end

  // ====================================================================
  // Key repeat timer
  // ====================================================================

  assign rpt_strobe = (rpt_count == RPT_W'(REPEAT_CYCLES - 1));

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      rpt_count <= '0;
    else if (rpt_strobe)
      rpt_count <= '0;
    else
      rpt_count <= rpt_count + 1'b1;
  end

  // ====================================================================
  // Divider register
  // ====================================================================

  // Up shortens the period, so it lowers the divider
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      rate_count <= DEFAULT_DIV;
    else if (!reset_sync[1])
      rate_count <= DEFAULT_DIV;
    else if (rpt_strobe && !up_sync[1])
    begin
      if (rate_count < MIN_DIV + SPEED_STEP)
        rate_count <= MIN_DIV;
      else
        rate_count <= rate_count - SPEED_STEP;
    end
    else if (rpt_strobe && !down_sync[1])
    begin
      if (rate_count > MAX_DIV - SPEED_STEP)
        rate_count <= MAX_DIV;
      else
        rate_count <= rate_count + SPEED_STEP;
    end
  end

endmodule

`default_nettype wire

// File: playback_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module playback_ctrl (
  input  wire                     CLK_50M,
  input  wire                     arst_n,
  input  wire ipod_cmd_pkg::ascii_t ascii_code,
  input  wire                     ascii_valid,
  output logic                    play,
  output ipod_cmd_pkg::dir_e      dir,
  output logic                    restart
);

  // Command decode, either case accepted
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      play <= 1'b0;
      dir <= ipod_cmd_pkg::DIR_FORWARD;
      restart <= 1'b0;
    end
    else
    begin
      restart <= 1'b0;
      if (ascii_valid)
      begin
        case (ascii_code)
          ipod_cmd_pkg::CMD_PLAY_C,
          ipod_cmd_pkg::CMD_PLAY_LC_C:
            play <= 1'b1;
          ipod_cmd_pkg::CMD_PAUSE_C,
          ipod_cmd_pkg::CMD_PAUSE_LC_C:
            play <= 1'b0;
          ipod_cmd_pkg::CMD_FWD_C,
          ipod_cmd_pkg::CMD_FWD_LC_C:
            dir <= ipod_cmd_pkg::DIR_FORWARD;
          ipod_cmd_pkg::CMD_BACK_C,
          ipod_cmd_pkg::CMD_BACK_LC_C:
            dir <= ipod_cmd_pkg::DIR_BACKWARD;
          ipod_cmd_pkg::CMD_RESTART_C,
          ipod_cmd_pkg::CMD_RESTART_LC_C:
            restart <= 1'b1;
          // Anything else is ignored
          default:
          begin
          end
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: sample_clock.sv
`timescale 1ns/1ps
`default_nettype none

module sample_clock (
  input  wire                       CLK_50M,
  input  wire                       arst_n,
  input  wire ipod_types_pkg::div_t rate_count,
  output logic                      tick
);

  ipod_types_pkg::div_t count;

  // Counts rate_count down to zero, so one tick per rate_count+1 cycles
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      count <= '0;
      tick <= 1'b0;
    end
    else if (count == '0)
    begin
      // New divider value picked up only here
      count <= rate_count;
      tick <= 1'b1;
    end
    else
    begin
      count <= count - 1'b1;
      tick <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: flash_reader.sv
`timescale 1ns/1ps
`default_nettype none

module flash_reader #(
  parameter ipod_types_pkg::addr_t LAST_ADDR = ipod_types_pkg::LAST_ADDR_C
) (
  input  wire                         CLK_50M,
  input  wire                         arst_n,
  input  wire                         tick,
  input  wire                         play,
  input  wire ipod_cmd_pkg::dir_e     dir,
  input  wire                         restart,
  output logic                        flash_read,
  output ipod_types_pkg::addr_t       flash_address,
  input  wire                         flash_waitrequest,
  input  wire ipod_types_pkg::word_t  flash_readdata,
  input  wire                         flash_readdatavalid,
  output ipod_types_pkg::sample_t     sample,
  output logic                        sample_valid
);

  ipod_cmd_pkg::reader_state_e state;
  ipod_cmd_pkg::dir_e          dir_q;
  ipod_types_pkg::word_t       word_q;
  logic                        restart_pend;

  logic take_word;
  logic emit_second;

  assign take_word = (state == ipod_cmd_pkg::ST_WAIT_DATA) && flash_readdatavalid;
  assign emit_second = (state == ipod_cmd_pkg::ST_SECOND_HALF) && !restart_pend &&
                       tick && play;

  // ====================================================================
  // Read sequencer
  // ====================================================================

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state <= ipod_cmd_pkg::ST_IDLE;
      dir_q <= ipod_cmd_pkg::DIR_FORWARD;
      flash_read <= 1'b0;
      flash_address <= '0;
      restart_pend <= 1'b0;
      sample_valid <= 1'b0;
    end
    else
    begin
      sample_valid <= take_word || emit_second;
      if (restart)
        restart_pend <= 1'b1;
      case (state)
        ipod_cmd_pkg::ST_IDLE:
        begin
          if (restart_pend)
          begin
            // Restart point depends on the direction in force now
            if (dir == ipod_cmd_pkg::DIR_BACKWARD)
              flash_address <= LAST_ADDR;
            else
              flash_address <= '0;
            if (!restart)
              restart_pend <= 1'b0;
          end
          else if (tick && play)
          begin
            dir_q <= dir;
            flash_read <= 1'b1;
            state <= ipod_cmd_pkg::ST_REQUEST;
          end
        end
        ipod_cmd_pkg::ST_REQUEST:
        begin
          // Address held until the flash accepts
          if (!flash_waitrequest)
          begin
            flash_read <= 1'b0;
            state <= ipod_cmd_pkg::ST_WAIT_DATA;
          end
        end
        ipod_cmd_pkg::ST_WAIT_DATA:
        begin
          if (take_word)
            state <= ipod_cmd_pkg::ST_SECOND_HALF;
        end
        ipod_cmd_pkg::ST_SECOND_HALF:
        begin
          // A pending restart drops the rest of this word
          if (restart_pend)
            state <= ipod_cmd_pkg::ST_IDLE;
          else if (emit_second)
          begin
            state <= ipod_cmd_pkg::ST_IDLE;
            if (dir_q == ipod_cmd_pkg::DIR_FORWARD)
              flash_address <= (flash_address == LAST_ADDR) ? '0 : flash_address + 1'b1;
            else
              flash_address <= (flash_address == '0) ? LAST_ADDR : flash_address - 1'b1;
          end
        end
        default:
          state <= ipod_cmd_pkg::ST_IDLE;
      endcase
    end
  end

  // ====================================================================
  // Word and sample registers
  // ====================================================================

  // Forward plays low half first, backward high half first
  always_ff @(posedge CLK_50M)
  begin
    if (take_word)
    begin
      word_q <= flash_readdata;
      if (dir_q == ipod_cmd_pkg::DIR_FORWARD)
        sample <= flash_readdata[15:0];
      else
        sample <= flash_readdata[31:16];
    end
    else if (emit_second)
    begin
      if (dir_q == ipod_cmd_pkg::DIR_FORWARD)
        sample <= word_q[31:16];
      else
        sample <= word_q[15:0];
    end
  end

endmodule

`default_nettype wire

// File: ipod_top.sv
`timescale 1ns/1ps
`default_nettype none

module ipod_top #(
  parameter ipod_types_pkg::div_t DEFAULT_DIV = ipod_types_pkg::DEFAULT_DIV_C,
  parameter ipod_types_pkg::div_t SPEED_STEP = ipod_types_pkg::SPEED_STEP_C,
  parameter ipod_types_pkg::div_t MIN_DIV = ipod_types_pkg::MIN_DIV_C,
  parameter ipod_types_pkg::div_t MAX_DIV = ipod_types_pkg::MAX_DIV_C,
  parameter int unsigned REPEAT_CYCLES = ipod_types_pkg::REPEAT_CYCLES_C,
  parameter ipod_types_pkg::addr_t LAST_ADDR = ipod_types_pkg::LAST_ADDR_C
) (
  input  wire                          CLK_50M,
  input  wire                          arst_n,
  input  wire                          speed_up_n,
  input  wire                          speed_down_n,
  input  wire                          speed_reset_n,
  input  wire ipod_cmd_pkg::ascii_t    ascii_code,
  input  wire                          ascii_valid,
  output wire                          flash_read,
  output ipod_types_pkg::addr_t        flash_address,
  input  wire                          flash_waitrequest,
  input  wire ipod_types_pkg::word_t   flash_readdata,
  input  wire                          flash_readdatavalid,
  output ipod_types_pkg::sample_t      sample,
  output wire                          sample_valid,
  output ipod_types_pkg::div_t         rate_count
);

  wire                play;
  ipod_cmd_pkg::dir_e dir;
  wire                restart;
  wire                tick;

  // ====================================================================
  // Control side
  // ====================================================================

  speed_ctrl #(
    .DEFAULT_DIV   (DEFAULT_DIV),
    .SPEED_STEP    (SPEED_STEP),
    .MIN_DIV       (MIN_DIV),
    .MAX_DIV       (MAX_DIV),
    .REPEAT_CYCLES (REPEAT_CYCLES)
  ) speed_ctrl_i (
    .CLK_50M       (CLK_50M),
    .arst_n        (arst_n),
    .speed_up_n    (speed_up_n),
    .speed_down_n  (speed_down_n),
    .speed_reset_n (speed_reset_n),
    .rate_count    (rate_count)
  );

  playback_ctrl playback_ctrl_i (
    .CLK_50M     (CLK_50M),
    .arst_n      (arst_n),
    .ascii_code  (ascii_code),
    .ascii_valid (ascii_valid),
    .play        (play),
    .dir         (dir),
    .restart     (restart)
  );

  // ====================================================================
  // Sample path
  // ====================================================================

  sample_clock sample_clock_i (
    .CLK_50M    (CLK_50M),
    .arst_n     (arst_n),
    .rate_count (rate_count),
    .tick       (tick)
  );

  flash_reader #(
    .LAST_ADDR (LAST_ADDR)
  ) flash_reader_i (
    .CLK_50M             (CLK_50M),
    .arst_n              (arst_n),
    .tick                (tick),
    .play                (play),
    .dir                 (dir),
    .restart             (restart),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .sample              (sample),
    .sample_valid        (sample_valid)
  );

endmodule

`default_nettype wire

// File: tb_ipod.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ipod;

  localparam ipod_types_pkg::div_t TB_DEFAULT_DIV = 16'd40;
  localparam ipod_types_pkg::div_t TB_STEP = 16'd4;
  localparam ipod_types_pkg::div_t TB_MIN_DIV = 16'd16;
  localparam ipod_types_pkg::div_t TB_MAX_DIV = 16'd80;
  localparam int unsigned TB_REPEAT = 50;
  localparam ipod_types_pkg::addr_t TB_LAST_ADDR = 23'd15;

  logic                           CLK_50M;
  logic                           arst_n;
  logic                           speed_up_n;
  logic                           speed_down_n;
  logic                           speed_reset_n;
  ipod_cmd_pkg::ascii_t           ascii_code;
  logic                           ascii_valid;
  wire                            flash_read;
  wire ipod_types_pkg::addr_t     flash_address;
  logic                           flash_waitrequest;
  ipod_types_pkg::word_t          flash_readdata;
  logic                           flash_readdatavalid;
  wire ipod_types_pkg::sample_t   sample;
  wire                            sample_valid;
  wire ipod_types_pkg::div_t      rate_count;

  // Expected playback position
  ipod_types_pkg::addr_t   exp_addr;
  logic                    exp_second;
  ipod_cmd_pkg::dir_e      cmd_dir;
  ipod_cmd_pkg::dir_e      word_dir;
  ipod_types_pkg::sample_t exp_sample;

  ipod_types_pkg::addr_t   fl_addr;
  logic                    read_busy;
  int                      sample_count;
  int                      mismatch_errors;
  int                      other_errors;

  ipod_top #(
    .DEFAULT_DIV   (TB_DEFAULT_DIV),
    .SPEED_STEP    (TB_STEP),
    .MIN_DIV       (TB_MIN_DIV),
    .MAX_DIV       (TB_MAX_DIV),
    .REPEAT_CYCLES (TB_REPEAT),
    .LAST_ADDR     (TB_LAST_ADDR)
  ) dut_i (
    .CLK_50M             (CLK_50M),
    .arst_n              (arst_n),
    .speed_up_n          (speed_up_n),
    .speed_down_n        (speed_down_n),
    .speed_reset_n       (speed_reset_n),
    .ascii_code          (ascii_code),
    .ascii_valid         (ascii_valid),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .sample              (sample),
    .sample_valid        (sample_valid),
    .rate_count          (rate_count)
  );

  // ====================================================================
  // Reference model
  // ====================================================================

  // Flash contents, every address bit shows up in the word
  function automatic ipod_types_pkg::word_t word_at(input ipod_types_pkg::addr_t a);
    word_at = {9'h1A5, a} ^ {a, 9'h0C3};
  endfunction

  // Forward gives low then high, backward high then low
  function automatic ipod_types_pkg::sample_t ref_sample(input ipod_types_pkg::addr_t a,
      input logic second, input ipod_cmd_pkg::dir_e d);
    ipod_types_pkg::word_t w;
    w = word_at(a);
    if ((d == ipod_cmd_pkg::DIR_FORWARD) != second)
      ref_sample = w[15:0];
    else
      ref_sample = w[31:16];
  endfunction

  // Addresses wrap modulo the number of words played
  function automatic ipod_types_pkg::addr_t next_addr(input ipod_types_pkg::addr_t a,
      input ipod_cmd_pkg::dir_e d);
    int unsigned span;
    span = TB_LAST_ADDR + 1;
    if (d == ipod_cmd_pkg::DIR_FORWARD)
      next_addr = ipod_types_pkg::addr_t'((a + 1) % span);
    else
      next_addr = ipod_types_pkg::addr_t'((a + span - 1) % span);
  endfunction

  // One repeat step of the divider, clamped to its range
  function automatic ipod_types_pkg::div_t step_rate(input ipod_types_pkg::div_t r,
      input logic up);
    ipod_types_pkg::div_t nxt;
    if (up)
    begin
      nxt = r - TB_STEP;
      if (r < TB_STEP || nxt < TB_MIN_DIV)
        nxt = TB_MIN_DIV;
    end
    else
    begin
      nxt = r + TB_STEP;
      if (nxt > TB_MAX_DIV)
        nxt = TB_MAX_DIV;
    end
    step_rate = nxt;
  endfunction

  initial
  begin
    CLK_50M = 1'b0;
    forever
      #10 CLK_50M = ~CLK_50M;
  end

  // Flash model, random back-pressure and latency
  initial
  begin
    void'($urandom(27604));
    flash_waitrequest = 1'b1;
    flash_readdatavalid = 1'b0;
    flash_readdata = '0;
    read_busy = 1'b0;
    forever
    begin
      @(negedge CLK_50M);
      if (flash_read === 1'b1)
      begin
        read_busy = 1'b1;
        fl_addr = flash_address;
        repeat ($urandom_range(0, 3)) @(negedge CLK_50M);
        // Address must hold until the request is accepted
        assert (flash_address === fl_addr)
        else
        begin
          mismatch_errors++;
          $display("mismatch flash_address: got %h expected %h", flash_address, fl_addr);
        end
        flash_waitrequest = 1'b0;
        @(negedge CLK_50M);
        flash_waitrequest = 1'b1;
        assert (flash_read === 1'b0)
        else
        begin
          mismatch_errors++;
          $display("mismatch flash_read: got %h expected %h", flash_read, 1'b0);
        end
        // Data 1 to 6 cycles after acceptance
        repeat ($urandom_range(0, 5)) @(negedge CLK_50M);
        flash_readdatavalid = 1'b1;
        flash_readdata = word_at(fl_addr);
        @(negedge CLK_50M);
        flash_readdatavalid = 1'b0;
        read_busy = 1'b0;
      end
    end
  end

  // Sample checker
  always @(negedge CLK_50M)
  begin
    if (arst_n && sample_valid)
    begin
      if (!exp_second)
        word_dir = cmd_dir;
      exp_sample = ref_sample(exp_addr, exp_second, word_dir);
      assert (sample === exp_sample)
      else
      begin
        mismatch_errors++;
        $display("mismatch sample: got %h expected %h at addr %h", sample, exp_sample,
                 exp_addr);
      end
      sample_count++;
      if (exp_second)
        exp_addr = next_addr(exp_addr, word_dir);
      exp_second = ~exp_second;
    end
  end

  // ====================================================================
  // Stimulus tasks
  // ====================================================================

  task automatic send_cmd(input ipod_cmd_pkg::ascii_t code);
    @(negedge CLK_50M);
    ascii_code = code;
    ascii_valid = 1'b1;
    @(negedge CLK_50M);
    ascii_valid = 1'b0;
    ascii_code = 8'h00;
  endtask

  task automatic wait_samples(input int n);
    int target;
    int cycles;
    target = sample_count + n;
    cycles = 0;
    while (sample_count < target && cycles < n * 200)
    begin
      @(negedge CLK_50M);
      cycles++;
    end
    assert (sample_count >= target)
    else
    begin
      other_errors++;
      $display("timeout waiting for %0d samples", n);
    end
  endtask

  task automatic expect_quiet(input int cycles);
    int start;
    start = sample_count;
    repeat (cycles) @(negedge CLK_50M);
    assert (sample_count == start)
    else
    begin
      other_errors++;
      $display("%0d samples appeared while playback was stopped", sample_count - start);
    end
  endtask

  // Pause, then let an outstanding read finish
  task automatic pause_playback();
    int cycles;
    send_cmd("d");
    cycles = 0;
    while ((flash_read || read_busy) && cycles < 100)
    begin
      @(negedge CLK_50M);
      cycles++;
    end
    assert (!(flash_read || read_busy))
    else
    begin
      other_errors++;
      $display("timeout waiting for the flash read to finish after pause");
    end
    repeat (2) @(negedge CLK_50M);
  endtask

  task automatic restart_playback(input ipod_cmd_pkg::dir_e d);
    pause_playback();
    if (d == ipod_cmd_pkg::DIR_FORWARD)
      send_cmd("F");
    else
      send_cmd("B");
    cmd_dir = d;
    send_cmd("r");
    exp_addr = (d == ipod_cmd_pkg::DIR_FORWARD) ? '0 : TB_LAST_ADDR;
    exp_second = 1'b0;
    send_cmd("E");
    wait_samples(6);
  endtask

  task automatic hold_speed_key(input logic up, input ipod_types_pkg::div_t bound);
    ipod_types_pkg::div_t prev;
    int cycles;
    @(negedge CLK_50M);
    if (up)
      speed_up_n = 1'b0;
    else
      speed_down_n = 1'b0;
    prev = rate_count;
    cycles = 0;
    while (cycles < 20 * TB_REPEAT && (rate_count != bound || cycles < 3 * TB_REPEAT))
    begin
      @(negedge CLK_50M);
      cycles++;
      if (rate_count != prev)
      begin
        assert (rate_count == step_rate(prev, up))
        else
        begin
          mismatch_errors++;
          $display("mismatch rate_count: got %h expected %h", rate_count,
                   step_rate(prev, up));
        end
        prev = rate_count;
      end
    end
    assert (rate_count == bound)
    else
    begin
      mismatch_errors++;
      $display("mismatch rate_count: got %h expected %h", rate_count, bound);
    end
    speed_up_n = 1'b1;
    speed_down_n = 1'b1;
  endtask

  // ====================================================================
  // Test sequence
  // ====================================================================

  initial
  begin
    arst_n = 1'b0;
    speed_up_n = 1'b1;
    speed_down_n = 1'b1;
    speed_reset_n = 1'b1;
    ascii_code = 8'h00;
    ascii_valid = 1'b0;
    exp_addr = '0;
    exp_second = 1'b0;
    cmd_dir = ipod_cmd_pkg::DIR_FORWARD;
    word_dir = ipod_cmd_pkg::DIR_FORWARD;
    sample_count = 0;
    mismatch_errors = 0;
    other_errors = 0;
    repeat (2) @(posedge CLK_50M);
    @(negedge CLK_50M);
    arst_n = 1'b1;

    assert (rate_count == TB_DEFAULT_DIV)
    else
    begin
      mismatch_errors++;
      $display("mismatch rate_count: got %h expected %h", rate_count, TB_DEFAULT_DIV);
    end
    expect_quiet(100);
    send_cmd("E");
    wait_samples(40);

    // Pause and resume at the same position
    pause_playback();
    expect_quiet(200);
    send_cmd("E");
    wait_samples(6);

    // Backward across the wrap, then forward again
    pause_playback();
    send_cmd("B");
    cmd_dir = ipod_cmd_pkg::DIR_BACKWARD;
    send_cmd("E");
    wait_samples(40);
    pause_playback();
    send_cmd("F");
    cmd_dir = ipod_cmd_pkg::DIR_FORWARD;
    send_cmd("E");
    wait_samples(8);

    restart_playback(ipod_cmd_pkg::DIR_FORWARD);
    restart_playback(ipod_cmd_pkg::DIR_BACKWARD);
    restart_playback(ipod_cmd_pkg::DIR_FORWARD);

    // Unknown codes while playing
    send_cmd("x");
    send_cmd("7");
    wait_samples(6);

    hold_speed_key(1'b1, TB_MIN_DIV);
    hold_speed_key(1'b0, TB_MAX_DIV);
    @(negedge CLK_50M);
    speed_reset_n = 1'b0;
    repeat (3) @(negedge CLK_50M);
    assert (rate_count == TB_DEFAULT_DIV)
    else
    begin
      mismatch_errors++;
      $display("mismatch rate_count: got %h expected %h", rate_count, TB_DEFAULT_DIV);
    end
    speed_reset_n = 1'b1;
    wait_samples(4);

    // Unknown codes while paused
    pause_playback();
    send_cmd("x");
    send_cmd("7");
    expect_quiet(100);

    $display("Samples checked %0d, mismatches %0d, other errors %0d", sample_count,
             mismatch_errors, other_errors);
    if (mismatch_errors == 0 && other_errors == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
ipod_types_pkg.sv
ipod_cmd_pkg.sv
speed_ctrl.sv
playback_ctrl.sv
sample_clock.sv
flash_reader.sv
ipod_top.sv
tb_ipod.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_ipod
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= Regression passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
